// ==== spk_geom_pkg.sv ====
/* Data geometry of the spiking patch-splitting stage.
   Lane, time-step and field widths shared by the RTL and the testbench model. */
`default_nettype none

package spk_geom_pkg;

    // Neurons in one psum row
    localparam int NUM_LANES  = 8;

    // Time steps per pixel
    localparam int TIME_STEPS = 4;

    // One signed partial sum from the array
    localparam int PSUM_W     = 16;

    // One embed count, pooled bit plus residual bit
    localparam int EMBED_W    = 2;

    // Spike and embed vectors are lane-major,
    // index = lane * TIME_STEPS + time step

endpackage

`default_nettype wire

// ==== spk_neuron_pkg.sv ====
/* Constants of the leaky integrate-and-fire neuron.
   Used by the neuron bank and by the testbench reference model. */
`default_nettype none

package spk_neuron_pkg;

    // Signed membrane potential width
    localparam int MEM_W      = 20;

    // Lane fires when the updated membrane reaches this value
    localparam int V_THRESH   = 256;

    // Leak is the membrane shifted right by this amount
    localparam int LEAK_SHIFT = 3;

endpackage

`default_nettype wire

// ==== lif_neuron_bank.sv ====
/* Leaky integrate-and-fire neurons, one per lane of a psum row.
   Collects one spike per lane and time step, then releases the whole row. */
`timescale 1ns/1ps
`default_nettype none

module lif_neuron_bank #(
    parameter int NUM_LANES  = spk_geom_pkg::NUM_LANES,
    parameter int TIME_STEPS = spk_geom_pkg::TIME_STEPS
) (
    input  wire                                              s_clk,
    input  wire                                              s_rst,
    input  wire                                              i_psum_valid,
    input  wire  [NUM_LANES*spk_geom_pkg::PSUM_W-1:0]         i_psums,
    output logic                                             o_spike_valid,
    output logic [NUM_LANES*TIME_STEPS-1:0]                  o_spikes
);

    localparam int PSUM_W = spk_geom_pkg::PSUM_W;
    localparam int MEM_W  = spk_neuron_pkg::MEM_W;
    localparam int STEP_W = $clog2(TIME_STEPS);
    localparam int ROW_W  = NUM_LANES * TIME_STEPS;

    logic signed [MEM_W-1:0]  r_mem      [NUM_LANES];
    logic signed [MEM_W-1:0]  w_mem_next [NUM_LANES];
    logic        [NUM_LANES-1:0] w_fire;
    logic        [STEP_W-1:0] r_step;
    logic        [ROW_W-1:0]  r_spike_acc;
    logic        [ROW_W-1:0]  w_spike_row;
    logic                     w_last_step;

    assign w_last_step = (r_step == STEP_W'(TIME_STEPS - 1));

    // Leak, integrate and threshold every lane for the current step
    always_comb begin
        logic signed [PSUM_W-1:0] psum;
        logic signed [MEM_W-1:0]  psum_ext;
        logic signed [MEM_W-1:0]  leak;
        logic signed [MEM_W-1:0]  sum;
        w_spike_row = r_spike_acc;
        for (int i = 0; i < NUM_LANES; i++) begin
            psum     = i_psums[i*PSUM_W +: PSUM_W];
            psum_ext = {{(MEM_W-PSUM_W){psum[PSUM_W-1]}}, psum};
            leak     = r_mem[i] >>> spk_neuron_pkg::LEAK_SHIFT;
            sum      = r_mem[i] - leak + psum_ext;
            w_fire[i] = (sum >= spk_neuron_pkg::V_THRESH);
            // Firing lanes restart from zero, and every lane clears after the row
            if (w_fire[i] || w_last_step) begin
                w_mem_next[i] = '0;
            end else begin
                w_mem_next[i] = sum;
            end
            w_spike_row[i*TIME_STEPS + int'(r_step)] = w_fire[i];
        end
    end

    always_ff @(posedge s_clk or posedge s_rst) begin
        if (s_rst) begin
            for (int i = 0; i < NUM_LANES; i++) begin
                r_mem[i] <= '0;
            end
            r_step        <= '0;
            o_spike_valid <= 1'b0;
        end else begin
            o_spike_valid <= i_psum_valid && w_last_step;
            if (i_psum_valid) begin
                for (int i = 0; i < NUM_LANES; i++) begin
                    r_mem[i] <= w_mem_next[i];
                end
                if (w_last_step) begin
                    r_step <= '0;
                end else begin
                    r_step <= r_step + 1'b1;
                end
            end
        end
    end

    // Each step overwrites its own bit, so the row is complete at the last step
    always_ff @(posedge s_clk) begin
        if (i_psum_valid) begin
            r_spike_acc <= w_spike_row;
            if (w_last_step) begin
                o_spikes <= w_spike_row;
            end
        end
    end

endmodule

`default_nettype wire

// ==== spike_maxpool.sv ====
/* 2x2 spike max-pool over lane pairs and row pairs.
   Even rows are stored, odd rows complete the window and emit a pooled row. */
`timescale 1ns/1ps
`default_nettype none

module spike_maxpool #(
    parameter int NUM_LANES  = spk_geom_pkg::NUM_LANES,
    parameter int TIME_STEPS = spk_geom_pkg::TIME_STEPS
) (
    input  wire                                   s_clk,
    input  wire                                   s_rst,
    input  wire                                   i_spike_valid,
    input  wire  [NUM_LANES*TIME_STEPS-1:0]       i_spikes,
    output logic                                  o_pool_valid,
    output logic [NUM_LANES/2*TIME_STEPS-1:0]     o_pool_spikes
);

    localparam int POOL_LANES = NUM_LANES / 2;
    localparam int POOL_W     = POOL_LANES * TIME_STEPS;

    logic [POOL_W-1:0] w_pair_or;
    logic [POOL_W-1:0] r_even_store;
    logic              r_odd_row;

    // Horizontal OR of lanes 2j and 2j+1, kept per time step
    always_comb begin
        for (int j = 0; j < POOL_LANES; j++) begin
            for (int t = 0; t < TIME_STEPS; t++) begin
                w_pair_or[j*TIME_STEPS + t] = i_spikes[(2*j)*TIME_STEPS + t]
                                            | i_spikes[(2*j+1)*TIME_STEPS + t];
            end
        end
    end

    always_ff @(posedge s_clk or posedge s_rst) begin
        if (s_rst) begin
            r_odd_row    <= 1'b0;
            r_even_store <= '0;
            o_pool_valid <= 1'b0;
        end else begin
            o_pool_valid <= i_spike_valid && r_odd_row;
            if (i_spike_valid) begin
                r_odd_row <= ~r_odd_row;
                if (!r_odd_row) begin
                    r_even_store <= w_pair_or;
                end
            end
        end
    end

    // Vertical OR with the stored even row closes the window
    always_ff @(posedge s_clk) begin
        if (i_spike_valid && r_odd_row) begin
            o_pool_spikes <= r_even_store | w_pair_or;
        end
    end

endmodule

`default_nettype wire

// ==== patch_embed_adder.sv ====
/* Patch-embed adder: holds the residual spike row and adds it to each
   pooled row, giving a small count per lane and time step. */
`timescale 1ns/1ps
`default_nettype none

module patch_embed_adder #(
    parameter int NUM_LANES  = spk_geom_pkg::NUM_LANES,
    parameter int TIME_STEPS = spk_geom_pkg::TIME_STEPS
) (
    input  wire                                                  s_clk,
    input  wire                                                  s_rst,
    input  wire                                                  i_patch_valid,
    input  wire  [NUM_LANES/2*TIME_STEPS-1:0]                    i_patch_spikes,
    input  wire                                                  i_pool_valid,
    input  wire  [NUM_LANES/2*TIME_STEPS-1:0]                    i_pool_spikes,
    output logic                                                 o_embed_valid,
    output logic [NUM_LANES/2*TIME_STEPS*spk_geom_pkg::EMBED_W-1:0] o_embed_data
);

    localparam int EMBED_W = spk_geom_pkg::EMBED_W;
    localparam int FIELDS  = NUM_LANES / 2 * TIME_STEPS;

    logic [FIELDS-1:0]         r_patch;
    logic [FIELDS*EMBED_W-1:0] w_sum;

    // Pooled bit plus residual bit, 0 to 2
    always_comb begin
        for (int k = 0; k < FIELDS; k++) begin
            w_sum[k*EMBED_W +: EMBED_W] = EMBED_W'(i_pool_spikes[k])
                                        + EMBED_W'(r_patch[k]);
        end
    end

    always_ff @(posedge s_clk or posedge s_rst) begin
        if (s_rst) begin
            r_patch       <= '0;
            o_embed_valid <= 1'b0;
        end else begin
            o_embed_valid <= i_pool_valid;
            if (i_patch_valid) begin
                r_patch <= i_patch_spikes;
            end
        end
    end

    always_ff @(posedge s_clk) begin
        if (i_pool_valid) begin
            o_embed_data <= w_sum;
        end
    end

endmodule

`default_nettype wire

// ==== sps_stage_top.sv ====
/* Top of the spiking patch-splitting stage: LIF bank, 2x2 spike pool and
   patch-embed adder in a strobe-driven chain. */
`timescale 1ns/1ps
`default_nettype none

module sps_stage_top #(
    parameter int NUM_LANES  = spk_geom_pkg::NUM_LANES,
    parameter int TIME_STEPS = spk_geom_pkg::TIME_STEPS
) (
    input  wire                                                  s_clk,
    input  wire                                                  s_rst,

    // One time step of one psum row
    input  wire                                                  i_psum_valid,
    input  wire  [NUM_LANES*spk_geom_pkg::PSUM_W-1:0]             i_psums,

    // Residual row, held until the next strobe
    input  wire                                                  i_patch_valid,
    input  wire  [NUM_LANES/2*TIME_STEPS-1:0]                    i_patch_spikes,

    // Spike row of the LIF bank
    output logic                                                 o_spike_valid,
    output logic [NUM_LANES*TIME_STEPS-1:0]                      o_spikes,

    // Embed counts, one per pooled lane and step
    output logic                                                 o_embed_valid,
    output logic [NUM_LANES/2*TIME_STEPS*spk_geom_pkg::EMBED_W-1:0] o_embed_data
);

    logic                              w_pool_valid;
    logic [NUM_LANES/2*TIME_STEPS-1:0] w_pool_spikes;

    lif_neuron_bank #(
        .NUM_LANES     ( NUM_LANES      ),
        .TIME_STEPS    ( TIME_STEPS     )
    ) u_lif_neuron_bank (
        .s_clk         ( s_clk          ),
        .s_rst         ( s_rst          ),
        .i_psum_valid  ( i_psum_valid   ),
        .i_psums       ( i_psums        ),
        .o_spike_valid ( o_spike_valid  ),
        .o_spikes      ( o_spikes       )
    );

    spike_maxpool #(
        .NUM_LANES     ( NUM_LANES      ),
        .TIME_STEPS    ( TIME_STEPS     )
    ) u_spike_maxpool (
        .s_clk         ( s_clk          ),
        .s_rst         ( s_rst          ),
        .i_spike_valid ( o_spike_valid  ),
        .i_spikes      ( o_spikes       ),
        .o_pool_valid  ( w_pool_valid   ),
        .o_pool_spikes ( w_pool_spikes  )
    );

    patch_embed_adder #(
        .NUM_LANES      ( NUM_LANES      ),
        .TIME_STEPS     ( TIME_STEPS     )
    ) u_patch_embed_adder (
        .s_clk          ( s_clk          ),
        .s_rst          ( s_rst          ),
        .i_patch_valid  ( i_patch_valid  ),
        .i_patch_spikes ( i_patch_spikes ),
        .i_pool_valid   ( w_pool_valid   ),
        .i_pool_spikes  ( w_pool_spikes  ),
        .o_embed_valid  ( o_embed_valid  ),
        .o_embed_data   ( o_embed_data   )
    );

endmodule

`default_nettype wire

// ==== sps_stage_checker.sv ====
/* Concurrent assertions on the strobe timing and reset state of the stage.
   Bound into the stage top level. */
`timescale 1ns/1ps
`default_nettype none

module sps_stage_checker (
    input wire s_clk,
    input wire s_rst,
    input wire i_psum_valid,
    input wire i_spike_valid,
    input wire i_embed_valid
);

    // Number of assertion failures so far
    int fail_count = 0;

    // Both strobes stay low while reset is held
    a_reset_quiet: assert property (
        @(posedge s_clk) s_rst |-> (!i_spike_valid && !i_embed_valid)
    ) else begin
        fail_count++;
        $error("strobe high during reset");
    end

    // Embed output is two stages behind the spike row
    a_embed_after_spike: assert property (
        @(posedge s_clk) disable iff (s_rst)
        i_embed_valid |-> $past(i_spike_valid, 2)
    ) else begin
        fail_count++;
        $error("embed strobe without a spike strobe two cycles earlier");
    end

    // A row needs at least two psum steps
    a_spike_single: assert property (
        @(posedge s_clk) disable iff (s_rst)
        i_spike_valid |=> !i_spike_valid
    ) else begin
        fail_count++;
        $error("spike strobe high on two consecutive cycles");
    end

    a_spike_after_psum: assert property (
        @(posedge s_clk) disable iff (s_rst)
        i_spike_valid |-> $past(i_psum_valid)
    ) else begin
        fail_count++;
        $error("spike strobe without a psum strobe one cycle earlier");
    end

endmodule

`default_nettype wire

// ==== tb_sps_stage.sv ====
/* Testbench for the spiking patch-splitting stage.
   Drives psum and residual rows, predicts spikes and embed counts, checks both. */
`timescale 1ns/1ps
`default_nettype none

module tb_sps_stage;

    localparam int NL          = spk_geom_pkg::NUM_LANES;
    localparam int TS          = spk_geom_pkg::TIME_STEPS;
    localparam int PSUM_W      = spk_geom_pkg::PSUM_W;
    localparam int EMBED_W     = spk_geom_pkg::EMBED_W;
    localparam int ROW_W       = NL * TS;
    localparam int POOL_W      = NL / 2 * TS;
    localparam int DRAIN_LIMIT = 64;

    logic                      s_clk = 1'b0;
    logic                      s_rst;
    logic                      i_psum_valid;
    logic [NL*PSUM_W-1:0]      i_psums;
    logic                      i_patch_valid;
    logic [POOL_W-1:0]         i_patch_spikes;
    logic                      o_spike_valid;
    logic [ROW_W-1:0]          o_spikes;
    logic                      o_embed_valid;
    logic [POOL_W*EMBED_W-1:0] o_embed_data;

    // Reference model state
    int                        mem [NL];
    int                        row_psum [TS][NL];
    logic                      row_odd;
    logic [POOL_W-1:0]         even_store;
    logic [POOL_W-1:0]         patch;

    logic [ROW_W-1:0]          exp_spk_q [$];
    int                        exp_spk_cyc_q [$];
    logic [POOL_W*EMBED_W-1:0] exp_emb_q [$];
    int                        exp_emb_cyc_q [$];
    logic [ROW_W-1:0]          last_spikes;

    int cycle = 0;
    int errors = 0;
    int checks = 0;
    int emb_seen = 0;
    int test_num = 0;
    int tests_failed = 0;
    int test_err_base = 0;
    int seed_init;
    int emb_before;

    sps_stage_top #(
        .NUM_LANES      ( NL             ),
        .TIME_STEPS     ( TS             )
    ) u_sps_stage_top (
        .s_clk          ( s_clk          ),
        .s_rst          ( s_rst          ),
        .i_psum_valid   ( i_psum_valid   ),
        .i_psums        ( i_psums        ),
        .i_patch_valid  ( i_patch_valid  ),
        .i_patch_spikes ( i_patch_spikes ),
        .o_spike_valid  ( o_spike_valid  ),
        .o_spikes       ( o_spikes       ),
        .o_embed_valid  ( o_embed_valid  ),
        .o_embed_data   ( o_embed_data   )
    );

    always #4 s_clk = ~s_clk;

    always @(posedge s_clk) begin
        cycle <= cycle + 1;
    end

    // Outputs are compared at the falling edge, half a cycle after they settle
    always @(negedge s_clk) begin : monitor
        logic [ROW_W-1:0]          exp_spk;
        logic [POOL_W*EMBED_W-1:0] exp_emb;
        int                        exp_cyc;
        if (s_rst) begin
            checks++;
            assert (!o_spike_valid && !o_embed_valid) else begin
                $display("A strobe is high during reset at cycle %0d", cycle);
                errors++;
            end
        end else begin
            if (o_spike_valid) begin
                last_spikes = o_spikes;
                if (exp_spk_q.size() == 0) begin
                    $display("Spike row strobe at cycle %0d with no row sent", cycle);
                    errors++;
                end else begin
                    exp_spk = exp_spk_q.pop_front();
                    exp_cyc = exp_spk_cyc_q.pop_front();
                    checks++;
                    assert (o_spikes === exp_spk) else begin
                        $display("CHECK FAILED o_spikes expected %h got %h", exp_spk, o_spikes);
                        errors++;
                    end
                    assert (cycle == exp_cyc) else begin
                        $display("Spike row strobe came at cycle %0d instead of %0d",
                                 cycle, exp_cyc);
                        errors++;
                    end
                end
            end
            if (o_embed_valid) begin
                emb_seen++;
                if (exp_emb_q.size() == 0) begin
                    $display("Embed strobe at cycle %0d with no odd row sent", cycle);
                    errors++;
                end else begin
                    exp_emb = exp_emb_q.pop_front();
                    exp_cyc = exp_emb_cyc_q.pop_front();
                    checks++;
                    assert (o_embed_data === exp_emb) else begin
                        $display("CHECK FAILED o_embed_data expected %h got %h",
                                 exp_emb, o_embed_data);
                        errors++;
                    end
                    assert (cycle == exp_cyc) else begin
                        $display("Embed strobe came at cycle %0d instead of %0d",
                                 cycle, exp_cyc);
                        errors++;
                    end
                end
            end
        end
    end

    task automatic tick();
        @(posedge s_clk);
        #1;
    endtask

    // Sends one row step by step and predicts its spikes, pool and embed
    task automatic send_row(input int max_gap);
        logic [ROW_W-1:0]          spk;
        logic [POOL_W-1:0]         pair;
        logic [POOL_W*EMBED_W-1:0] emb;
        int                        sum;
        int                        last_cyc;
        int                        gap;
        spk = '0;
        last_cyc = 0;
        for (int t = 0; t < TS; t++) begin
            gap = (max_gap > 0) ? int'($urandom % (max_gap + 1)) : 0;
            i_psum_valid = 1'b0;
            repeat (gap) tick();
            for (int l = 0; l < NL; l++) begin
                i_psums[l*PSUM_W +: PSUM_W] = PSUM_W'(row_psum[t][l]);
                sum = mem[l] - (mem[l] >>> spk_neuron_pkg::LEAK_SHIFT) + row_psum[t][l];
                if (sum >= spk_neuron_pkg::V_THRESH) begin
                    spk[l*TS + t] = 1'b1;
                    mem[l] = 0;
                end else begin
                    mem[l] = sum;
                end
            end
            i_psum_valid = 1'b1;
            last_cyc = cycle;
            tick();
        end
        i_psum_valid = 1'b0;
        for (int l = 0; l < NL; l++) begin
            mem[l] = 0;
        end
        exp_spk_q.push_back(spk);
        exp_spk_cyc_q.push_back(last_cyc + 1);
        for (int j = 0; j < NL / 2; j++) begin
            for (int t = 0; t < TS; t++) begin
                pair[j*TS + t] = spk[(2*j)*TS + t] | spk[(2*j+1)*TS + t];
            end
        end
        if (!row_odd) begin
            even_store = pair;
            row_odd = 1'b1;
        end else begin
            pair = pair | even_store;
            for (int k = 0; k < POOL_W; k++) begin
                emb[k*EMBED_W +: EMBED_W] = EMBED_W'(pair[k]) + EMBED_W'(patch[k]);
            end
            exp_emb_q.push_back(emb);
            exp_emb_cyc_q.push_back(last_cyc + 3);
            row_odd = 1'b0;
        end
    endtask

    // Waits until every predicted strobe has been seen
    task automatic drain();
        int n;
        n = 0;
        while ((exp_spk_q.size() != 0 || exp_emb_q.size() != 0) && n < DRAIN_LIMIT) begin
            tick();
            n++;
        end
        if (exp_spk_q.size() != 0 || exp_emb_q.size() != 0) begin
            $display("Timed out after %0d cycles waiting for spike or embed strobes", n);
            errors++;
            exp_spk_q.delete();
            exp_spk_cyc_q.delete();
            exp_emb_q.delete();
            exp_emb_cyc_q.delete();
        end
        repeat (3) tick();
    endtask

    task automatic set_patch(input logic [POOL_W-1:0] val);
        drain();
        i_patch_spikes = val;
        i_patch_valid = 1'b1;
        tick();
        i_patch_valid = 1'b0;
        patch = val;
    endtask

    task automatic fill_cycle(input int a, input int b, input int c, input int d);
        for (int t = 0; t < TS; t++) begin
            for (int l = 0; l < NL; l++) begin
                case (l % 4)
                    0: row_psum[t][l] = a;
                    1: row_psum[t][l] = b;
                    2: row_psum[t][l] = c;
                    default: row_psum[t][l] = d;
                endcase
            end
        end
    endtask

    // A set bit fires its lane at that step, a clear bit leaves the membrane at zero
    task automatic fill_pattern(input logic [ROW_W-1:0] pat);
        for (int t = 0; t < TS; t++) begin
            for (int l = 0; l < NL; l++) begin
                row_psum[t][l] = pat[l*TS + t] ? 300 : 0;
            end
        end
    endtask

    task automatic send_pair(input logic [ROW_W-1:0] even_pat, input logic [ROW_W-1:0] odd_pat);
        fill_pattern(even_pat);
        send_row(0);
        fill_pattern(odd_pat);
        send_row(0);
    endtask

    task automatic align_even();
        if (row_odd) begin
            fill_cycle(0, 0, 0, 0);
            send_row(0);
        end
        drain();
    endtask

    task automatic finish_test(input string name);
        test_num++;
        if (errors == test_err_base) begin
            $display("test %0d %s: ok", test_num, name);
        end else begin
            $display("test %0d %s: %0d errors", test_num, name, errors - test_err_base);
            tests_failed++;
        end
        test_err_base = errors;
    endtask

    initial begin
        s_rst = 1'b1;
        i_psum_valid = 1'b0;
        i_psums = '0;
        i_patch_valid = 1'b0;
        i_patch_spikes = '0;
        last_spikes = '0;
        row_odd = 1'b0;
        even_store = '0;
        patch = '0;
        for (int l = 0; l < NL; l++) begin
            mem[l] = 0;
        end
        seed_init = $urandom(67679);
        repeat (8) @(posedge s_clk);
        #1;
        s_rst = 1'b0;

        // First row after reset must be treated as even
        repeat (3) tick();
        fill_cycle(300, 0, 300, 0);
        send_row(0);
        drain();
        checks++;
        assert (emb_seen == 0) else begin
            $display("Embed strobe after the first row, which should be an even row");
            errors++;
        end
        fill_cycle(0, 0, 300, 300);
        send_row(0);
        drain();
        finish_test("reset state");

        fill_cycle(0, 100, 150, 300);
        send_row(0);
        fill_cycle(255, 256, 257, -100);
        send_row(0);
        drain();
        finish_test("threshold and leak");

        // Membranes end near 184 without firing, then must restart from zero
        for (int t = 0; t < TS; t++) begin
            for (int l = 0; l < NL; l++) begin
                row_psum[t][l] = (t == 0) ? 200 : ((t == TS - 1) ? 0 : 30);
            end
        end
        send_row(0);
        fill_cycle(0, 0, 0, 0);
        send_row(0);
        drain();
        checks++;
        assert (last_spikes == '0) else begin
            $display("CHECK FAILED o_spikes expected %h got %h", {ROW_W{1'b0}}, last_spikes);
            errors++;
        end
        fill_cycle(80, 80, 80, 80);
        send_row(0);
        drain();
        finish_test("row clear");

        align_even();
        emb_before = emb_seen;
        fill_pattern(ROW_W'(32'h1200_4081));
        send_row(0);
        drain();
        checks++;
        assert (emb_seen == emb_before) else begin
            $display("Embed strobe after an even row alone");
            errors++;
        end
        fill_pattern(ROW_W'(32'h0318_0240));
        send_row(2);
        send_pair(ROW_W'(32'hFFFF_0000), ROW_W'(32'h0000_00FF));
        drain();
        finish_test("pooling");

        align_even();
        set_patch('0);
        send_pair(ROW_W'(32'h1200_4081), ROW_W'(32'h0318_0240));
        set_patch('1);
        send_pair(ROW_W'(32'h1200_4081), ROW_W'(32'h0318_0240));
        set_patch(POOL_W'(16'hA5C3));
        send_pair(ROW_W'(32'h1200_4081), ROW_W'(32'h0318_0240));
        set_patch(POOL_W'(16'h5A3C));
        send_pair(ROW_W'(32'h8421_1248), ROW_W'(32'h0000_0000));
        drain();
        finish_test("embed sum");

        align_even();
        for (int r = 0; r < 40; r++) begin
            if (r % 2 == 0 && $urandom % 3 == 0) begin
                set_patch(POOL_W'($urandom));
            end
            for (int t = 0; t < TS; t++) begin
                for (int l = 0; l < NL; l++) begin
                    row_psum[t][l] = int'($urandom % 501) - 150;
                end
            end
            send_row(2);
        end
        drain();
        finish_test("random stream");

        errors = errors + u_sps_stage_top.u_checker.fail_count;
        $display("tests %0d, failed %0d, checks %0d, errors %0d",
                 test_num, tests_failed, checks, errors);
        if (errors == 0) begin
            $display(">>> PASS");
        end else begin
            $display(">>> FAIL");
        end
        $finish;
    end

endmodule

bind sps_stage_top sps_stage_checker u_checker (
    .s_clk         ( s_clk         ),
    .s_rst         ( s_rst         ),
    .i_psum_valid  ( i_psum_valid  ),
    .i_spike_valid ( o_spike_valid ),
    .i_embed_valid ( o_embed_valid )
);

`default_nettype wire

// ==== sim.f ====
spk_geom_pkg.sv
spk_neuron_pkg.sv
lif_neuron_bank.sv
spike_maxpool.sv
patch_embed_adder.sv
sps_stage_top.sv
sps_stage_checker.sv
tb_sps_stage.sv

// ==== run_sim.sh ====
#!/usr/bin/env bash
# Build the stage testbench with Verilator, run it and scan the log
cd "$(dirname "$0")" || exit 1
rm -f sim.log
verilator --binary --timing --assert -Wno-fatal --top-module tb_sps_stage -f sim.f -o vsim \
    && ./obj_dir/vsim +verilator+error+limit+100 > sim.log 2>&1 \
    || echo "build or simulation exited with an error"
cat sim.log 2>/dev/null
grep -q ">>> FAIL" sim.log && { echo "simulation failed"; exit 1; }
grep -q ">>> PASS" sim.log || { echo "simulation did not pass"; exit 1; }
echo "simulation passed"
